// ==== bench/tb_clock_gen.sv ====
/* testbench clock and reset
   4 ns clock, reset held low for 8 cycles */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic resetn_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        resetn_o = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o) resetn_o = 1'b1; // released away from the active edge
    end

endmodule

`default_nettype wire

// ==== bench/tb_mem_wb.sv ====
/* table-driven testbench for the memory and write-back back end
   host preload, loads, stores, register writes and host/load contention */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wb
    import rv_isa_pkg::*;
;
    typedef enum int {K_HWRITE, K_HREAD, K_EXEC, K_RCHK, K_LOAD_HOST} kind_e;

    logic clk, resetn;
    logic ex_give, ex_get;
    logic [31:0] ex_instr, ex_alu, ex_store;
    logic host_req, host_we, host_grant, host_rvalid;
    logic [3:0] host_be;
    logic [31:0] host_addr, host_wdata, host_rdata;
    logic [4:0] rs;
    logic [31:0] rs_data;

    kind_e       t_kind [128];
    logic [31:0] t_instr [128], t_addr [128], t_data [128], t_exp [128];
    int n_entries = 0;
    int errors = 0;
    int cycles = 0;
    int limit;

    tb_clock_gen u_clk (.clk_o(clk), .resetn_o(resetn));

    mem_wb_top #(.XLEN(32), .DMEM_WORDS(256)) uut (
        .clk(clk), .resetn_i(resetn),
        .ex_give_i(ex_give), .ex_get_o(ex_get), .ex_instr_i(ex_instr),
        .ex_alu_i(ex_alu), .ex_store_i(ex_store),
        .host_req_i(host_req), .host_we_i(host_we), .host_be_i(host_be),
        .host_addr_i(host_addr), .host_wdata_i(host_wdata), .host_grant_o(host_grant),
        .host_rvalid_o(host_rvalid), .host_rdata_o(host_rdata),
        .rs_i(rs), .rs_data_o(rs_data)
    );

    function automatic logic [31:0] make_instr(rv_opcode_e op, logic [2:0] f3, logic [4:0] rd);
        return {17'd0, f3, rd, op};
    endfunction

    // lane select and extension as a load sees it
    function automatic logic [31:0] load_expect(logic [31:0] word, logic [2:0] f3,
                                                logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[off*8 +: 8];
        h = word[off[1]*16 +: 16];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b100:  return {24'd0, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b101:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] store_merge(logic [31:0] word, logic [2:0] f3,
                                                logic [1:0] off, logic [31:0] data);
        logic [31:0] w;
        w = word;
        if (f3 == 3'b000) w[off*8 +: 8] = data[7:0];
        else if (f3 == 3'b001) w[off[1]*16 +: 16] = data[15:0];
        else w = data;
        return w;
    endfunction

    task automatic add_entry(kind_e k, logic [31:0] instr, logic [31:0] addr,
                             logic [31:0] data, logic [31:0] exp);
        t_kind[n_entries]  = k;
        t_instr[n_entries] = instr;
        t_addr[n_entries]  = addr;
        t_data[n_entries]  = data;
        t_exp[n_entries]   = exp;
        n_entries++;
    endtask

    task automatic host_access(logic we, logic [31:0] addr, logic [31:0] wdata,
                               output logic [31:0] rdata, output int waits);
        waits = 0;
        @(negedge clk);
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        host_be    = 4'hf;
        #1;
        while (!host_grant) begin
            @(negedge clk);
            #1;
            waits++; // cycles spent behind the memory stage
        end
        @(negedge clk);
        host_req = 1'b0;
        #1;
        while (!host_rvalid) begin
            @(negedge clk);
            #1;
        end
        rdata = host_rdata;
    endtask

    task automatic exec_instr(logic [31:0] instr, logic [31:0] alu, logic [31:0] store);
        @(negedge clk);
        ex_give  = 1'b1;
        ex_instr = instr;
        ex_alu   = alu;
        ex_store = store;
        #1;
        while (!ex_get) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        ex_give = 1'b0;
        repeat (8) @(negedge clk); // idle gap before any register check
    endtask

    task automatic check_reg(logic [4:0] rd, logic [31:0] exp);
        @(negedge clk);
        rs = rd;
        #1;
        if (rs_data !== exp) begin
            $display("Error %0t: x%0d is %h, expected %h", $time, rd, rs_data, exp);
            errors++;
        end
    endtask

    task automatic check_host(logic [31:0] got, logic [31:0] exp, logic [31:0] addr);
        if (got !== exp) begin
            $display("Error %0t: host read %h gave %h, expected %h", $time, addr, got, exp);
            errors++;
        end
    endtask

    task automatic build_table();
        logic [31:0] w0, w1, w2, w3, s;
        w0 = $urandom;
        w1 = $urandom;
        w2 = $urandom;
        w3 = $urandom;
        s  = $urandom;
        add_entry(K_HWRITE, 0, 32'h10, w0, 0);
        add_entry(K_HREAD, 0, 32'h10, 0, w0);
        add_entry(K_EXEC, make_instr(OP_LOAD, LS_WORD, 5'd1), 32'h10, 0, 0);
        add_entry(K_RCHK, 0, 1, 0, w0);
        for (int off = 0; off < 4; off++) begin
            add_entry(K_EXEC, make_instr(OP_LOAD, LS_BYTE, 5'd2), 32'h10 + off, 0, 0);
            add_entry(K_RCHK, 0, 2, 0, load_expect(w0, 3'b000, 2'(off)));
            add_entry(K_EXEC, make_instr(OP_LOAD, LS_BYTE_U, 5'd3), 32'h10 + off, 0, 0);
            add_entry(K_RCHK, 0, 3, 0, load_expect(w0, 3'b100, 2'(off)));
            add_entry(K_EXEC, make_instr(OP_LOAD, LS_HALF, 5'd4), 32'h10 + off, 0, 0);
            add_entry(K_RCHK, 0, 4, 0, load_expect(w0, 3'b001, 2'(off)));
            add_entry(K_EXEC, make_instr(OP_LOAD, LS_HALF_U, 5'd5), 32'h10 + off, 0, 0);
            add_entry(K_RCHK, 0, 5, 0, load_expect(w0, 3'b101, 2'(off)));
        end
        // partial stores into one word, model updated after each
        add_entry(K_HWRITE, 0, 32'h20, w1, 0);
        for (int off = 0; off < 4; off++) begin
            w1 = store_merge(w1, 3'b000, 2'(off), s + off);
            add_entry(K_EXEC, make_instr(OP_STORE, LS_BYTE, 5'd0), 32'h20 + off, s + off, 0);
            add_entry(K_HREAD, 0, 32'h20, 0, w1);
        end
        for (int off = 0; off < 4; off += 2) begin
            w1 = store_merge(w1, 3'b001, 2'(off), ~s);
            add_entry(K_EXEC, make_instr(OP_STORE, LS_HALF, 5'd0), 32'h20 + off, ~s, 0);
            add_entry(K_HREAD, 0, 32'h20, 0, w1);
        end
        add_entry(K_EXEC, make_instr(OP_IMM_ALU, 3'b000, 5'd6), 32'h1234_5678, 0, 0);
        add_entry(K_EXEC, make_instr(OP_REG_ALU, 3'b000, 5'd7), 32'hdead_beef, 0, 0);
        add_entry(K_EXEC, make_instr(OP_LUI, 3'b000, 5'd8), 32'habcd_e000, 0, 0);
        add_entry(K_EXEC, make_instr(OP_JAL, 3'b000, 5'd9), 32'h0000_0104, 0, 0);
        add_entry(K_RCHK, 0, 6, 0, 32'h1234_5678);
        add_entry(K_RCHK, 0, 7, 0, 32'hdead_beef);
        add_entry(K_RCHK, 0, 8, 0, 32'habcd_e000);
        add_entry(K_RCHK, 0, 9, 0, 32'h0000_0104);
        // no register write for x0, store or branch
        add_entry(K_EXEC, make_instr(OP_IMM_ALU, 3'b000, 5'd0), 32'h5555_aaaa, 0, 0);
        add_entry(K_EXEC, make_instr(OP_STORE, LS_WORD, 5'd10), 32'h40, w2, 0);
        add_entry(K_EXEC, make_instr(OP_BRANCH, 3'b000, 5'd11), 32'h77, 0, 0);
        add_entry(K_RCHK, 0, 0, 0, 0);
        add_entry(K_RCHK, 0, 10, 0, 0);
        add_entry(K_RCHK, 0, 11, 0, 0);
        add_entry(K_RCHK, 0, 6, 0, 32'h1234_5678);
        add_entry(K_HREAD, 0, 32'h40, 0, w2);
        // host read raised while the load requests memory
        add_entry(K_HWRITE, 0, 32'h30, w2, 0);
        add_entry(K_HWRITE, 0, 32'h34, w3, 0);
        add_entry(K_LOAD_HOST, make_instr(OP_LOAD, LS_WORD, 5'd12), 32'h30, 32'h34, w3);
        add_entry(K_RCHK, 0, 12, 0, w2);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0] rdata;
        int          waits;
        ex_give = 1'b0;
        ex_instr = '0;
        ex_alu = '0;
        ex_store = '0;
        host_req = 1'b0;
        host_we = 1'b0;
        host_be = '0;
        host_addr = '0;
        host_wdata = '0;
        rs = '0;
        limit = 100000; // until the table is known
        void'($urandom(32'h6a38eaea));
        build_table();
        limit = n_entries * 40 + 8 + 40; // plus the reset checks
        wait (resetn === 1'b1);
        @(negedge clk);
        if (ex_get !== 1'b1 || host_grant !== 1'b0 || host_rvalid !== 1'b0) begin
            $display("Error %0t: idle outputs wrong after reset", $time);
            errors++;
        end
        for (int r = 0; r < 32; r++) check_reg(5'(r), 0);
        for (int i = 0; i < n_entries; i++) begin
            case (t_kind[i])
                K_HWRITE: host_access(1'b1, t_addr[i], t_data[i], rdata, waits);
                K_HREAD: begin
                    host_access(1'b0, t_addr[i], 0, rdata, waits);
                    check_host(rdata, t_exp[i], t_addr[i]);
                end
                K_EXEC: exec_instr(t_instr[i], t_addr[i], t_data[i]);
                K_RCHK: check_reg(t_addr[i][4:0], t_exp[i]);
                default: begin
                    fork
                        exec_instr(t_instr[i], t_addr[i], 0);
                        begin
                            @(negedge clk); // host request lands on the load's access cycle
                            host_access(1'b0, t_data[i], 0, rdata, waits);
                        end
                    join
                    if (waits == 0) begin
                        $display("Error %0t: host granted while the load held the port",
                                 $time);
                        errors++;
                    end
                    check_host(rdata, t_exp[i], t_data[i]);
                end
            endcase
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/data_mem.sv ====
/* data memory
   word-wide synchronous ram, byte-enable writes, registered read data */
`timescale 1ns/1ps
`default_nettype none

module data_mem
    import mem_sys_pkg::*;
#(
    parameter int XLEN       = DEF_XLEN,
    parameter int DMEM_WORDS = DEF_DMEM_WORDS
) (
    input  wire                           clk,
    input  wire                           en_i,
    input  wire                           we_i,
    input  wire  [XLEN/8-1:0]             be_i,
    input  wire  [$clog2(DMEM_WORDS)-1:0] addr_i,
    input  wire  [XLEN-1:0]               wdata_i,
    output logic [XLEN-1:0]               rdata_o
);

    logic [XLEN-1:0] mem [DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < XLEN/8; b++) begin
                    if (be_i[b]) mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
            rdata_o <= mem[addr_i]; // old word on a write
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dmem_arbiter.sv ====
/* data memory arbiter
   fixed priority, memory stage before host, one access per cycle */
`timescale 1ns/1ps
`default_nettype none

module dmem_arbiter
    import mem_sys_pkg::*;
#(
    parameter int XLEN       = DEF_XLEN,
    parameter int DMEM_WORDS = DEF_DMEM_WORDS
) (
    input  wire                          clk,
    input  wire                          resetn_i,
    input  wire                          m_req_i,
    input  wire                          m_we_i,
    input  wire  [XLEN/8-1:0]            m_be_i,
    input  wire  [XLEN-1:0]              m_addr_i,
    input  wire  [XLEN-1:0]              m_wdata_i,
    output logic                         m_gnt_o,
    output logic                         m_rvalid_o,
    output logic [XLEN-1:0]              m_rdata_o,
    input  wire                          h_req_i,
    input  wire                          h_we_i,
    input  wire  [XLEN/8-1:0]            h_be_i,
    input  wire  [XLEN-1:0]              h_addr_i,
    input  wire  [XLEN-1:0]              h_wdata_i,
    output logic                         h_gnt_o,
    output logic                         h_rvalid_o,
    output logic [XLEN-1:0]              h_rdata_o,
    output logic                         mem_en_o,
    output logic                         mem_we_o,
    output logic [XLEN/8-1:0]            mem_be_o,
    output logic [$clog2(DMEM_WORDS)-1:0] mem_addr_o,
    output logic [XLEN-1:0]              mem_wdata_o,
    input  wire  [XLEN-1:0]              mem_rdata_i
);

    localparam int AW = $clog2(DMEM_WORDS);

    arb_req_e          owner_q;  // who gets the next read data
    logic              rvalid_q;
    logic [XLEN-1:0]   sel_addr;

    assign m_gnt_o  = m_req_i;
    assign h_gnt_o  = h_req_i && !m_req_i;
    assign mem_en_o = m_req_i || h_req_i;

    assign mem_we_o    = m_req_i ? m_we_i    : h_we_i;
    assign mem_be_o    = m_req_i ? m_be_i    : h_be_i;
    assign mem_wdata_o = m_req_i ? m_wdata_i : h_wdata_i;
    assign sel_addr    = m_req_i ? m_addr_i  : h_addr_i;
    assign mem_addr_o  = sel_addr[AW+1:2]; // byte address to word index

    always_ff @(posedge clk) begin
        if (!resetn_i) begin
            owner_q  <= REQ_MEM;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= mem_en_o;
            if (mem_en_o) owner_q <= m_req_i ? REQ_MEM : REQ_HOST;
        end
    end

    assign m_rvalid_o = rvalid_q && (owner_q == REQ_MEM);
    assign h_rvalid_o = rvalid_q && (owner_q == REQ_HOST);
    assign m_rdata_o  = mem_rdata_i;
    assign h_rdata_o  = mem_rdata_i;

    // exclusive grants, and each host grant is answered to the host alone
    a_one_grant: assert property (@(posedge clk) disable iff (!resetn_i)
        h_gnt_o |-> !m_gnt_o ##1 h_rvalid_o && !m_rvalid_o)
        else $error("host grant not answered, owner %s", owner_q.name());

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
/* memory stage
   runs loads and stores against the data memory port, forwards other results */
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import rv_isa_pkg::*, mem_sys_pkg::*;
#(
    parameter int XLEN = DEF_XLEN
) (
    input  wire                  clk,
    input  wire                  resetn_i,
    input  wire                  ex_give_i,
    output logic                 ex_get_o,
    input  wire  [31:0]          ex_instr_i,
    input  wire  [XLEN-1:0]      ex_alu_i,
    input  wire  [XLEN-1:0]      ex_store_i,
    input  wire                  wb_get_i,
    output logic                 wb_give_o,
    output logic [31:0]          wb_instr_o,
    output logic [XLEN-1:0]      wb_data_o,
    output logic                 dm_req_o,
    output logic                 dm_we_o,
    output logic [XLEN/8-1:0]    dm_be_o,
    output logic [XLEN-1:0]      dm_addr_o,
    output logic [XLEN-1:0]      dm_wdata_o,
    input  wire                  dm_gnt_i,
    input  wire                  dm_rvalid_i,
    input  wire  [XLEN-1:0]      dm_rdata_i
);

    localparam int BE_W = XLEN/8;

    typedef enum logic [1:0] {S_IDLE, S_ACCESS, S_WAIT, S_HANDOFF} state_e;

    state_e           state;
    logic [31:0]      instr_q;
    logic [XLEN-1:0]  alu_q;
    logic [XLEN-1:0]  store_q;
    logic [XLEN-1:0]  data_q;
    rv_opcode_e       op_in, op_q;
    ls_width_e        width;
    logic [1:0]       off;      // byte offset inside the word
    logic [XLEN-1:0]  lane_b, lane_h;
    logic [XLEN-1:0]  load_val;

    assign op_in = rv_opcode_e'(ex_instr_i[OPCODE_MSB:OPCODE_LSB]);
    assign op_q  = rv_opcode_e'(instr_q[OPCODE_MSB:OPCODE_LSB]);
    assign width = ls_width_e'(instr_q[FUNCT3_MSB:FUNCT3_LSB]);
    assign off   = alu_q[1:0];

    always_ff @(posedge clk) begin
        if (!resetn_i) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (ex_give_i) begin
                    state <= (op_in == OP_LOAD || op_in == OP_STORE) ? S_ACCESS : S_HANDOFF;
                end
                S_ACCESS: if (dm_gnt_i) state <= S_WAIT;
                S_WAIT:   if (dm_rvalid_i) state <= S_HANDOFF;
                default:  if (wb_get_i) state <= S_IDLE; // hand-off done
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && ex_give_i) begin
            instr_q <= ex_instr_i;
            alu_q   <= ex_alu_i;
            store_q <= ex_store_i;
            data_q  <= ex_alu_i;   // result of non-memory ops
        end else if (state == S_WAIT && dm_rvalid_i && op_q == OP_LOAD) begin
            data_q  <= load_val;
        end
    end

    // request side, misaligned addresses drop to their natural boundary
    always_comb begin
        dm_be_o    = {BE_W{1'b1}};
        dm_wdata_o = store_q;
        case (width)
            LS_BYTE: begin
                dm_be_o    = BE_W'(1) << off;
                dm_wdata_o = store_q << {off, 3'b000};
            end
            LS_HALF: begin
                dm_be_o    = BE_W'(3) << {off[1], 1'b0};
                dm_wdata_o = store_q << {off[1], 4'b0000};
            end
            default: ;
        endcase
    end

    assign dm_req_o  = (state == S_ACCESS);
    assign dm_we_o   = (op_q == OP_STORE);
    assign dm_addr_o = {alu_q[XLEN-1:2], 2'b00};

    // lane select and extension of load data
    assign lane_b = dm_rdata_i >> {off, 3'b000};
    assign lane_h = dm_rdata_i >> {off[1], 4'b0000};

    always_comb begin
        case (width)
            LS_BYTE:   load_val = {{(XLEN-8){lane_b[7]}}, lane_b[7:0]};
            LS_BYTE_U: load_val = {{(XLEN-8){1'b0}}, lane_b[7:0]};
            LS_HALF:   load_val = {{(XLEN-16){lane_h[15]}}, lane_h[15:0]};
            LS_HALF_U: load_val = {{(XLEN-16){1'b0}}, lane_h[15:0]};
            default:   load_val = dm_rdata_i;
        endcase
    end

    assign ex_get_o   = (state == S_IDLE);
    assign wb_give_o  = (state == S_HANDOFF);
    assign wb_instr_o = instr_q;
    assign wb_data_o  = data_q;

    // request and its payload are held until the arbiter grants
    a_req_held: assert property (@(posedge clk) disable iff (!resetn_i)
        dm_req_o && !dm_gnt_i |=> dm_req_o && $stable(dm_addr_o) && $stable(dm_be_o))
        else $error("dm request dropped or changed before grant");

endmodule

`default_nettype wire

// ==== hdl/mem_sys_pkg.sv ====
/* memory system definitions
   arbiter requester names and default sizing */
`default_nettype none

package mem_sys_pkg;

    // owners of the data memory port
    typedef enum logic {
        REQ_MEM  = 1'b0,
        REQ_HOST = 1'b1
    } arb_req_e;

    localparam int DEF_XLEN       = 32;  // data width in bits
    localparam int DEF_DMEM_WORDS = 256; // memory depth in words

endpackage

`default_nettype wire

// ==== hdl/mem_wb_top.sv ====
/* pipeline back end top
   memory stage, write-back, register file and shared data memory */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top
    import mem_sys_pkg::*;
#(
    parameter int XLEN       = DEF_XLEN,
    parameter int DMEM_WORDS = DEF_DMEM_WORDS
) (
    input  wire                clk,
    input  wire                resetn_i,
    input  wire                ex_give_i,
    output logic               ex_get_o,
    input  wire  [31:0]        ex_instr_i,
    input  wire  [XLEN-1:0]    ex_alu_i,
    input  wire  [XLEN-1:0]    ex_store_i,
    input  wire                host_req_i,
    input  wire                host_we_i,
    input  wire  [XLEN/8-1:0]  host_be_i,
    input  wire  [XLEN-1:0]    host_addr_i,
    input  wire  [XLEN-1:0]    host_wdata_i,
    output logic               host_grant_o,
    output logic               host_rvalid_o,
    output logic [XLEN-1:0]    host_rdata_o,
    input  wire  [4:0]         rs_i,
    output logic [XLEN-1:0]    rs_data_o
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic               mem_wb_give, wb_mem_get;
    logic [31:0]        mem_wb_instr;
    logic [XLEN-1:0]    mem_wb_data;
    logic               reg_we;
    logic [4:0]         reg_rd;
    logic [XLEN-1:0]    reg_wdata;

    logic               dm_req, dm_we, dm_gnt, dm_rvalid;
    logic [XLEN/8-1:0]  dm_be;
    logic [XLEN-1:0]    dm_addr, dm_wdata, dm_rdata;

    logic               ram_en, ram_we;
    logic [XLEN/8-1:0]  ram_be;
    logic [AW-1:0]      ram_addr;
    logic [XLEN-1:0]    ram_wdata, ram_rdata;

    mem_stage #(.XLEN(XLEN)) u_mem_stage (
        .clk(clk), .resetn_i(resetn_i),
        .ex_give_i(ex_give_i), .ex_get_o(ex_get_o), .ex_instr_i(ex_instr_i),
        .ex_alu_i(ex_alu_i), .ex_store_i(ex_store_i),
        .wb_get_i(wb_mem_get), .wb_give_o(mem_wb_give),
        .wb_instr_o(mem_wb_instr), .wb_data_o(mem_wb_data),
        .dm_req_o(dm_req), .dm_we_o(dm_we), .dm_be_o(dm_be), .dm_addr_o(dm_addr),
        .dm_wdata_o(dm_wdata), .dm_gnt_i(dm_gnt), .dm_rvalid_i(dm_rvalid),
        .dm_rdata_i(dm_rdata)
    );

    wb_stage #(.XLEN(XLEN)) u_wb_stage (
        .clk(clk), .resetn_i(resetn_i),
        .mem_give_i(mem_wb_give), .mem_get_o(wb_mem_get),
        .mem_instr_i(mem_wb_instr), .mem_data_i(mem_wb_data),
        .reg_we_o(reg_we), .reg_rd_o(reg_rd), .reg_wdata_o(reg_wdata)
    );

    regfile #(.XLEN(XLEN)) u_regfile (
        .clk(clk), .resetn_i(resetn_i),
        .we_i(reg_we), .rd_i(reg_rd), .wdata_i(reg_wdata),
        .rs_i(rs_i), .rs_data_o(rs_data_o)
    );

    dmem_arbiter #(.XLEN(XLEN), .DMEM_WORDS(DMEM_WORDS)) u_arbiter (
        .clk(clk), .resetn_i(resetn_i),
        .m_req_i(dm_req), .m_we_i(dm_we), .m_be_i(dm_be), .m_addr_i(dm_addr),
        .m_wdata_i(dm_wdata), .m_gnt_o(dm_gnt), .m_rvalid_o(dm_rvalid),
        .m_rdata_o(dm_rdata),
        .h_req_i(host_req_i), .h_we_i(host_we_i), .h_be_i(host_be_i),
        .h_addr_i(host_addr_i), .h_wdata_i(host_wdata_i), .h_gnt_o(host_grant_o),
        .h_rvalid_o(host_rvalid_o), .h_rdata_o(host_rdata_o),
        .mem_en_o(ram_en), .mem_we_o(ram_we), .mem_be_o(ram_be),
        .mem_addr_o(ram_addr), .mem_wdata_o(ram_wdata), .mem_rdata_i(ram_rdata)
    );

    data_mem #(.XLEN(XLEN), .DMEM_WORDS(DMEM_WORDS)) u_data_mem (
        .clk(clk), .en_i(ram_en), .we_i(ram_we), .be_i(ram_be),
        .addr_i(ram_addr), .wdata_i(ram_wdata), .rdata_o(ram_rdata)
    );

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
/* integer register file
   31 writable registers, one write port and one combinational read port */
`timescale 1ns/1ps
`default_nettype none

module regfile
    import mem_sys_pkg::*;
#(
    parameter int XLEN = DEF_XLEN
) (
    input  wire              clk,
    input  wire              resetn_i,
    input  wire              we_i,
    input  wire  [4:0]       rd_i,
    input  wire  [XLEN-1:0]  wdata_i,
    input  wire  [4:0]       rs_i,
    output logic [XLEN-1:0]  rs_data_o
);

    logic [XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!resetn_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // decode read port in the full core
    always_comb begin
        if (rs_i == 5'd0) begin
            rs_data_o = '0;
        end else begin
            rs_data_o = regs[rs_i];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
/* rv32i instruction set definitions
   major opcodes, load/store widths and instruction field positions */
`default_nettype none

package rv_isa_pkg;

    // 7-bit major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_BRANCH  = 7'b1100011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_IMM_ALU = 7'b0010011,
        OP_REG_ALU = 7'b0110011
    } rv_opcode_e;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        LS_BYTE   = 3'b000,
        LS_HALF   = 3'b001,
        LS_WORD   = 3'b010,
        LS_BYTE_U = 3'b100,
        LS_HALF_U = 3'b101
    } ls_width_e;

    // instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;

    localparam int RD_LSB = 7;
    localparam int RD_MSB = 11;

    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;

endpackage

`default_nettype wire

// ==== hdl/wb_stage.sv ====
/* write-back stage
   takes one instruction from the memory stage and writes rd when the opcode asks */
`timescale 1ns/1ps
`default_nettype none

module wb_stage
    import rv_isa_pkg::*, mem_sys_pkg::*;
#(
    parameter int XLEN = DEF_XLEN
) (
    input  wire              clk,
    input  wire              resetn_i,
    input  wire              mem_give_i,
    output logic             mem_get_o,
    input  wire  [31:0]      mem_instr_i,
    input  wire  [XLEN-1:0]  mem_data_i,
    output logic             reg_we_o,
    output logic [4:0]       reg_rd_o,
    output logic [XLEN-1:0]  reg_wdata_o
);

    typedef enum logic {S_GET, S_WRITE} state_e;

    state_e           state;
    logic [31:0]      instr_q;
    logic [XLEN-1:0]  data_q;
    logic             writes_rd;

    always_ff @(posedge clk) begin
        if (!resetn_i) begin
            state <= S_GET;
        end else if (state == S_GET) begin
            if (mem_give_i) state <= S_WRITE;
        end else begin
            state <= S_GET; // single write cycle
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_GET && mem_give_i) begin
            instr_q <= mem_instr_i;
            data_q  <= mem_data_i;
        end
    end

    // store and branch never touch the register file
    always_comb begin
        case (rv_opcode_e'(instr_q[OPCODE_MSB:OPCODE_LSB]))
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
            OP_LOAD, OP_IMM_ALU, OP_REG_ALU: writes_rd = 1'b1;
            default:                         writes_rd = 1'b0;
        endcase
    end

    assign mem_get_o   = (state == S_GET);
    assign reg_rd_o    = instr_q[RD_MSB:RD_LSB];
    assign reg_wdata_o = data_q;
    assign reg_we_o    = (state == S_WRITE) && writes_rd && (reg_rd_o != 5'd0);

    // a write always follows a transfer and never targets x0
    a_we_valid: assert property (@(posedge clk) disable iff (!resetn_i)
        reg_we_o |-> (reg_rd_o != 5'd0) && $past(mem_give_i && mem_get_o))
        else $error("register write without transfer or to x0");

endmodule

`default_nettype wire

// ==== list.f ====
hdl/rv_isa_pkg.sv
hdl/mem_sys_pkg.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/regfile.sv
hdl/dmem_arbiter.sv
hdl/data_mem.sv
hdl/mem_wb_top.sv
bench/tb_clock_gen.sv
bench/tb_mem_wb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the back end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tb_mem_wb -f list.f -o sim_mem_wb

out=$(./obj_dir/sim_mem_wb)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
    exit 0
else
    exit 1
fi
